// ==== project.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/pipe_stage.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/operand_select.sv
verilog/execute_unit.sv
verilog/branch_redirect.sv
verilog/core_top.sv
verif/core_asserts.sv
verif/core_tb.sv

// ==== verif/core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module core_tb;
    import core_pkg::*;

    localparam int MAX_ROWS  = 64;
    localparam int NUM_TESTS = 6;
    localparam int NUM_REDIR = 4;

    logic      clk;
    logic      arst_n_i;
    logic      fetch_valid_i;
    word_t     fetch_pc_i;
    word_t     fetch_inst_i;
    logic      fetch_ready_o;
    logic      redirect_valid_o;
    word_t     redirect_addr_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;

    // program table with one row per pc
    word_t     prog_inst [MAX_ROWS];
    logic      row_has   [MAX_ROWS];
    reg_addr_t row_rd    [MAX_ROWS];
    word_t     row_val   [MAX_ROWS];
    int        row_test  [MAX_ROWS];
    int        n_rows;

    // expected retires in program order
    reg_addr_t exp_rd    [$];
    word_t     exp_val   [$];
    int        exp_test  [$];
    word_t     exp_redir [NUM_REDIR];
    int        test_end  [NUM_TESTS+1];
    int        test_chk  [NUM_TESTS+1];
    int        test_err  [NUM_TESTS+1];

    int        exp_idx;
    int        redir_idx;
    int        cycles;
    int        limit;
    int        total_chk;
    int        total_err;
    integer    seed;
    logic      running;
    logic      ready_low_seen;

    core_top u_dut (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_ready_o    (fetch_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_addr_o  (redirect_addr_o),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o)
    );

    bind core_top core_asserts u_asserts (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fetch_ready_o    (fetch_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o)
    );

    always #50 clk = !clk;

    ////////////////////////////////////////
    // instruction encoders

    function automatic word_t r_type_inst(input logic [6:0] f7, input int rd, input int rs1,
                                          input int rs2, input logic [2:0] f3);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_OP};
    endfunction

    function automatic word_t i_type_inst(input int rd, input int rs1, input int imm,
                                          input logic [2:0] f3);
        return {12'(imm), 5'(rs1), f3, 5'(rd), `OPC_OP_IMM};
    endfunction

    function automatic word_t b_type_inst(input int rs1, input int rs2, input int imm,
                                          input logic [2:0] f3);
        logic [12:0] o;
        o = 13'(imm);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], `OPC_BRANCH};
    endfunction

    function automatic word_t j_type_inst(input int rd, input int imm);
        logic [20:0] o;
        o = 21'(imm);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), `OPC_JAL};
    endfunction

    function automatic word_t u_type_inst(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), `OPC_LUI};
    endfunction

    task automatic add_row(input word_t inst, input logic has, input int rd,
                           input word_t val, input int t);
        prog_inst[n_rows] = inst;
        row_has[n_rows]   = has;
        row_rd[n_rows]    = 5'(rd);
        row_val[n_rows]   = val;
        row_test[n_rows]  = t;
        n_rows++;
    endtask

    function automatic word_t fetch_word(input word_t pc);
        if ((pc >> 2) < n_rows) begin
            return prog_inst[pc >> 2];
        end
        return '0;
    endfunction

    task automatic build_program();
        n_rows = 0;
        // alu, immediate and lui
        add_row(i_type_inst(1, 0, 5, 3'b000), 1, 1, 32'd5, 1);
        add_row(i_type_inst(2, 0, -3, 3'b000), 1, 2, 32'hffff_fffd, 1);
        add_row(r_type_inst(7'h00, 3, 1, 2, 3'b000), 1, 3, 32'd2, 1);
        add_row(r_type_inst(7'h20, 4, 1, 2, 3'b000), 1, 4, 32'd8, 1);
        add_row(r_type_inst(7'h00, 5, 1, 2, 3'b111), 1, 5, 32'd5, 1);
        add_row(r_type_inst(7'h00, 6, 1, 2, 3'b110), 1, 6, 32'hffff_fffd, 1);
        add_row(r_type_inst(7'h00, 7, 1, 2, 3'b100), 1, 7, 32'hffff_fff8, 1);
        add_row(r_type_inst(7'h00, 8, 2, 1, 3'b010), 1, 8, 32'd1, 1);
        add_row(u_type_inst(9, 20'h12345), 1, 9, 32'h1234_5000, 1);
        add_row(i_type_inst(10, 9, 32'h678, 3'b110), 1, 10, 32'h1234_5678, 1);
        add_row(i_type_inst(11, 10, -1, 3'b100), 1, 11, 32'hedcb_a987, 1);
        add_row(i_type_inst(12, 10, 32'hff, 3'b111), 1, 12, 32'h0000_0078, 1);
        // dependent chain
        add_row(i_type_inst(13, 0, 7, 3'b000), 1, 13, 32'd7, 2);
        add_row(r_type_inst(7'h00, 14, 13, 13, 3'b000), 1, 14, 32'd14, 2);
        add_row(r_type_inst(7'h00, 15, 14, 13, 3'b000), 1, 15, 32'd21, 2);
        add_row(r_type_inst(7'h20, 16, 15, 14, 3'b000), 1, 16, 32'd7, 2);
        add_row(r_type_inst(7'h00, 17, 16, 15, 3'b100), 1, 17, 32'd18, 2);
        // taken branches whose fall-through rows must not retire
        add_row(b_type_inst(13, 16, 8, 3'b000), 0, 0, '0, 3);
        add_row(i_type_inst(20, 0, 99, 3'b000), 0, 0, '0, 3);
        add_row(b_type_inst(13, 14, 8, 3'b001), 0, 0, '0, 3);
        add_row(i_type_inst(20, 0, 98, 3'b000), 0, 0, '0, 3);
        add_row(b_type_inst(2, 1, 8, 3'b100), 0, 0, '0, 3);
        add_row(i_type_inst(20, 0, 97, 3'b000), 0, 0, '0, 3);
        add_row(j_type_inst(18, 8), 1, 18, 32'd96, 3);
        add_row(i_type_inst(20, 0, 96, 3'b000), 0, 0, '0, 3);
        // not-taken branches
        add_row(b_type_inst(13, 14, 8, 3'b000), 0, 0, '0, 4);
        add_row(i_type_inst(19, 0, 11, 3'b000), 1, 19, 32'd11, 4);
        add_row(b_type_inst(13, 16, 8, 3'b001), 0, 0, '0, 4);
        add_row(b_type_inst(1, 2, 8, 3'b100), 0, 0, '0, 4);
        add_row(i_type_inst(21, 19, 1, 3'b000), 1, 21, 32'd12, 4);
        // multiply and its dependents
        add_row(r_type_inst(7'h01, 22, 1, 2, 3'b000), 1, 22, 32'hffff_fff1, 5);
        add_row(r_type_inst(7'h00, 23, 22, 1, 3'b000), 1, 23, 32'hffff_fff6, 5);
        add_row(r_type_inst(7'h01, 24, 10, 13, 3'b000), 1, 24, 32'h7f6e_5d48, 5);
        add_row(i_type_inst(25, 24, -8, 3'b000), 1, 25, 32'h7f6e_5d40, 5);
        // mixed chain under fetch gaps
        add_row(i_type_inst(26, 25, 32'h10, 3'b000), 1, 26, 32'h7f6e_5d50, 6);
        add_row(r_type_inst(7'h00, 27, 23, 0, 3'b010), 1, 27, 32'd1, 6);
        add_row(r_type_inst(7'h00, 28, 27, 26, 3'b000), 1, 28, 32'h7f6e_5d51, 6);
        add_row(i_type_inst(29, 28, 32'h200, 3'b110), 1, 29, 32'h7f6e_5f51, 6);
        add_row(r_type_inst(7'h20, 31, 29, 28, 3'b000), 1, 31, 32'h0000_0200, 6);

        exp_redir[0] = 32'd76;
        exp_redir[1] = 32'd84;
        exp_redir[2] = 32'd92;
        exp_redir[3] = 32'd100;
    endtask

    ////////////////////////////////////////
    // fetch model

    always @(posedge clk) begin
        word_t nxt;
        if (running) begin
            if (redirect_valid_o) begin
                nxt = redirect_addr_o;
            end else if (fetch_valid_i && fetch_ready_o) begin
                nxt = fetch_pc_i + 32'd4;
            end else begin
                nxt = fetch_pc_i;
            end
            fetch_pc_i    <= nxt;
            fetch_inst_i  <= fetch_word(nxt);
            fetch_valid_i <= ($random(seed) & 3) != 0;
        end
    end

    ////////////////////////////////////////
    // retire and redirect monitor

    task automatic finish_test(input int t);
        if (t == 5) begin
            test_chk[t]++;
            assert (ready_low_seen) else begin
                $display("fetch_ready_o never went low during the multiply test");
                test_err[t]++;
            end
        end
        if (t == 3 || t == 4) begin
            test_chk[t]++;
            assert (redir_idx == NUM_REDIR) else begin
                $display("** Error at %0t: %0d redirects seen, expected %0d",
                         $time, redir_idx, NUM_REDIR);
                test_err[t]++;
            end
        end
        $display("test %0d done: %0d checks, %0d errors", t, test_chk[t], test_err[t]);
    endtask

    always @(posedge clk) begin
        int t;
        if (running) begin
            cycles++;
            if (!fetch_ready_o && exp_idx < exp_rd.size() && exp_test[exp_idx] == 5) begin
                ready_low_seen = 1'b1;
            end
            if (redirect_valid_o) begin
                if (redir_idx < NUM_REDIR) begin
                    test_chk[3]++;
                    assert (redirect_addr_o == exp_redir[redir_idx]) else begin
                        $display("** Error at %0t: redirect to %h, expected %h",
                                 $time, redirect_addr_o, exp_redir[redir_idx]);
                        test_err[3]++;
                    end
                end else begin
                    $display("unexpected redirect to %h at %0t", redirect_addr_o, $time);
                    test_err[4]++;
                end
                redir_idx++;
            end
            if (retire_valid_o) begin
                if (exp_idx < exp_rd.size()) begin
                    t = exp_test[exp_idx];
                    test_chk[t]++;
                    assert (retire_rd_o == exp_rd[exp_idx] &&
                            retire_data_o == exp_val[exp_idx]) else begin
                        $display("** Error at %0t: retire x%0d=%h, expected x%0d=%h",
                                 $time, retire_rd_o, retire_data_o,
                                 exp_rd[exp_idx], exp_val[exp_idx]);
                        test_err[t]++;
                    end
                    exp_idx++;
                    if (exp_idx == test_end[t]) begin
                        finish_test(t);
                    end
                end else begin
                    $display("extra retire of x%0d after the program at %0t",
                             retire_rd_o, $time);
                    test_err[NUM_TESTS]++;
                end
            end
            if (cycles >= limit) begin
                $display("timeout after %0d cycles, %0d of %0d retires seen",
                         cycles, exp_idx, exp_rd.size());
                $display("TB FAILED");
                $finish;
            end
        end
    end

    ////////////////////////////////////////
    // main sequence

    initial begin
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        fetch_valid_i  = 1'b0;
        fetch_pc_i     = `RESET_PC;
        fetch_inst_i   = '0;
        seed           = 32'h0c4e_8d6c;
        running        = 1'b0;
        ready_low_seen = 1'b0;
        exp_idx        = 0;
        redir_idx      = 0;
        cycles         = 0;
        total_chk      = 0;
        total_err      = 0;
        for (int i = 0; i <= NUM_TESTS; i++) begin
            test_chk[i] = 0;
            test_err[i] = 0;
        end

        build_program();
        limit = n_rows * (`MUL_CYCLES + 8);
        // walk the table into the expected retire order
        for (int r = 0; r < n_rows; r++) begin
            if (row_has[r]) begin
                exp_rd.push_back(row_rd[r]);
                exp_val.push_back(row_val[r]);
                exp_test.push_back(row_test[r]);
                test_end[row_test[r]] = exp_rd.size();
            end
        end

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        test_chk[1]++;
        assert (!retire_valid_o && !redirect_valid_o && fetch_ready_o) else begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            test_err[1]++;
        end
        @(posedge clk);
        running <= 1'b1;

        wait (exp_idx == exp_rd.size());
        // drain to catch late extra retires or redirects
        repeat (12) @(negedge clk);

        for (int i = 0; i <= NUM_TESTS; i++) begin
            total_chk += test_chk[i];
            total_err += test_err[i];
        end
        $display("checks %0d, errors %0d, cycles %0d", total_chk, total_err, cycles);
        if (total_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/core_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_asserts (
    input wire                      clk,
    input wire                      arst_n_i,
    input wire                      fetch_ready_o,
    input wire                      redirect_valid_o,
    input wire                      retire_valid_o,
    input wire core_pkg::reg_addr_t retire_rd_o
);
    import core_pkg::*;

    // x0 writes never show on the retire port
    retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        retire_valid_o |-> retire_rd_o != '0
    ) else $error("retire strobe with rd zero");

    redirect_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        redirect_valid_o |=> !redirect_valid_o
    ) else $error("redirect high on two cycles in a row");

    ctrl_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown({redirect_valid_o, retire_valid_o, fetch_ready_o})
    ) else $error("unknown value on a control output");

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_top (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  fetch_valid_i,
    input  wire core_pkg::word_t fetch_pc_i,
    input  wire core_pkg::word_t fetch_inst_i,
    output logic                 fetch_ready_o,
    output logic                 redirect_valid_o,
    output core_pkg::word_t      redirect_addr_o,
    output logic                 retire_valid_o,
    output core_pkg::reg_addr_t  retire_rd_o,
    output core_pkg::word_t      retire_data_o
);
    import core_pkg::*;

    // decode
    logic    id_valid;
    id_pay_t id_in;
    id_pay_t id_pay;
    ctrl_t   id_ctrl;
    word_t   id_imm;
    logic    id_flush;
    logic    id_stall;
    logic    id_load;

    // operand
    logic    ds_valid;
    ds_pay_t ds_in;
    ds_pay_t ds_pay;
    logic    ds_stall;

    // execute
    logic    ex_valid;
    logic    ex_is_new;
    ex_pay_t ex_in;
    ex_pay_t ex_pay;
    word_t   ex_result;
    logic    ex_taken;
    word_t   ex_target;
    logic    ex_mul_busy;
    logic    ex_stall;
    logic    br_fail;
    logic    br_wait;

    // writeback
    logic    wb_valid;
    wb_pay_t wb_in;
    wb_pay_t wb_pay;
    word_t   regs [32];
    fwd_t    fw_ex;
    fwd_t    fw_wb;

    ////////////////////////////////////////
    // stall chain and flush

    assign ex_stall      = ex_mul_busy | br_wait | br_fail;
    assign ds_stall      = ds_valid & ex_stall;
    assign id_stall      = id_valid & ds_stall;
    assign fetch_ready_o = !id_stall;

    // decode is cleared on the detect edge and again on the redirect edge
    assign id_flush = br_fail | redirect_valid_o;
    assign id_load  = fetch_valid_i & fetch_ready_o & !id_flush;

    ////////////////////////////////////////
    // stages

    assign id_in = '{pc: fetch_pc_i, inst: fetch_inst_i};

    pipe_stage #(.payload_t(id_pay_t)) u_id_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (id_flush),
        .hold_i   (id_stall),
        .bubble_i (1'b0),
        .valid_i  (fetch_valid_i),
        .data_i   (id_in),
        .valid_o  (id_valid),
        .is_new_o (),
        .data_o   (id_pay)
    );

    inst_decoder u_decoder (
        .inst_i (id_pay.inst),
        .ctrl_o (id_ctrl),
        .imm_o  (id_imm)
    );

    assign ds_in = '{pc: id_pay.pc, inst: id_pay.inst, ctrl: id_ctrl, imm: id_imm};

    pipe_stage #(.payload_t(ds_pay_t)) u_ds_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (br_fail),
        .hold_i   (ds_stall),
        .bubble_i (1'b0),
        .valid_i  (id_valid),
        .data_i   (ds_in),
        .valid_o  (ds_valid),
        .is_new_o (),
        .data_o   (ds_pay)
    );

    assign fw_ex = '{valid: ex_valid & ex_pay.ctrl.rf_wen, rd: ex_pay.ctrl.rd,
                     data: ex_result};
    assign fw_wb = '{valid: wb_valid & wb_pay.rf_wen, rd: wb_pay.rd, data: wb_pay.data};

    assign ex_in.pc   = ds_pay.pc;
    assign ex_in.ctrl = ds_pay.ctrl;

    operand_select u_operand_select (
        .regs_i  (regs),
        .ctrl_i  (ds_pay.ctrl),
        .inst_i  (ds_pay.inst),
        .imm_i   (ds_pay.imm),
        .fw_ex_i (fw_ex),
        .fw_wb_i (fw_wb),
        .op1_o   (ex_in.op1),
        .op2_o   (ex_in.op2),
        .rs2_o   (ex_in.rs2)
    );

    // the operand stage only holds behind a held execute stage
    pipe_stage #(.payload_t(ex_pay_t)) u_ex_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (1'b0),
        .hold_i   (ex_stall),
        .bubble_i (1'b0),
        .valid_i  (ds_valid),
        .data_i   (ex_in),
        .valid_o  (ex_valid),
        .is_new_o (ex_is_new),
        .data_o   (ex_pay)
    );

    execute_unit u_execute (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .valid_i    (ex_valid),
        .is_new_i   (ex_is_new),
        .pay_i      (ex_pay),
        .result_o   (ex_result),
        .taken_o    (ex_taken),
        .target_o   (ex_target),
        .mul_busy_o (ex_mul_busy)
    );

    branch_redirect u_branch_redirect (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .ex_valid_i       (ex_valid),
        .ex_is_new_i      (ex_is_new),
        .ex_pc_i          (ex_pay.pc),
        .taken_i          (ex_taken),
        .target_i         (ex_target),
        .ds_valid_i       (ds_valid),
        .ds_pc_i          (ds_pay.pc),
        .id_valid_i       (id_valid),
        .id_pc_i          (id_pay.pc),
        .id_load_i        (id_load),
        .fail_o           (br_fail),
        .wait_o           (br_wait),
        .redirect_valid_o (redirect_valid_o),
        .redirect_addr_o  (redirect_addr_o)
    );

    assign wb_in = '{rf_wen: ex_pay.ctrl.rf_wen, rd: ex_pay.ctrl.rd, data: ex_result};

    // held execute leaves a bubble and writeback never stalls
    pipe_stage #(.payload_t(wb_pay_t)) u_wb_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (1'b0),
        .hold_i   (1'b0),
        .bubble_i (ex_stall),
        .valid_i  (ex_valid),
        .data_i   (wb_in),
        .valid_o  (wb_valid),
        .is_new_o (),
        .data_o   (wb_pay)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wen_i    (wb_valid & wb_pay.rf_wen),
        .waddr_i  (wb_pay.rd),
        .wdata_i  (wb_pay.data),
        .regs_o   (regs)
    );

    ////////////////////////////////////////
    // retire port

    assign retire_valid_o = wb_valid & wb_pay.rf_wen & (wb_pay.rd != '0);
    assign retire_rd_o    = wb_pay.rd;
    assign retire_data_o  = wb_pay.data;

endmodule

`default_nettype wire

// ==== verilog/branch_redirect.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module branch_redirect (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  ex_valid_i,
    input  wire                  ex_is_new_i,
    input  wire core_pkg::word_t ex_pc_i,
    input  wire                  taken_i,
    input  wire core_pkg::word_t target_i,
    input  wire                  ds_valid_i,
    input  wire core_pkg::word_t ds_pc_i,
    input  wire                  id_valid_i,
    input  wire core_pkg::word_t id_pc_i,
    input  wire                  id_load_i,
    output logic                 fail_o,
    output logic                 wait_o,
    output logic                 redirect_valid_o,
    output core_pkg::word_t      redirect_addr_o
);
    import core_pkg::*;

    word_t next_pc;
    logic  checked_q;
    logic  unchecked;

    assign next_pc = taken_i ? target_i : ex_pc_i + word_t'(4);

    // a new instruction in execute is always checked
    assign unchecked = ex_valid_i & (ex_is_new_i | !checked_q);

    // compare with the next younger instruction
    assign fail_o = unchecked & (ds_valid_i ? ds_pc_i != next_pc :
                                 id_valid_i & (id_pc_i != next_pc));
    assign wait_o = unchecked & !ds_valid_i & !id_valid_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            checked_q        <= 1'b0;
            redirect_valid_o <= 1'b0;
            redirect_addr_o  <= `RESET_PC;
        end else begin
            if (fail_o) begin
                checked_q <= 1'b1;
            end else if (id_load_i) begin
                checked_q <= 1'b0;
            end
            // keeps fetch off the execute compare path
            redirect_valid_o <= fail_o;
            redirect_addr_o  <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module execute_unit (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   valid_i,
    input  wire                   is_new_i,
    input  wire core_pkg::ex_pay_t pay_i,
    output core_pkg::word_t       result_o,
    output logic                  taken_o,
    output core_pkg::word_t       target_o,
    output logic                  mul_busy_o
);
    import core_pkg::*;

    localparam int CNT_W = $clog2(`MUL_CYCLES);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MUL_CYCLES - 1);

    ////////////////////////////////////////
    // shift-add multiplier

    logic             is_mul;
    logic             mul_first;
    logic             mul_step;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cur_cnt;
    word_t            acc_q;
    word_t            cand_q;
    word_t            plier_q;
    word_t            cur_acc;
    word_t            cur_cand;
    word_t            cur_plier;
    word_t            mul_sum;

    assign is_mul    = pay_i.ctrl.alu_op == ALU_MUL;
    assign mul_first = valid_i & is_new_i & is_mul;

    // first cycle works straight from the operands
    assign cur_cnt   = mul_first ? '0 : cnt_q;
    assign cur_acc   = mul_first ? '0 : acc_q;
    assign cur_cand  = mul_first ? pay_i.op1 : cand_q;
    assign cur_plier = mul_first ? pay_i.op2 : plier_q;
    assign mul_sum   = cur_acc + (cur_plier[0] ? cur_cand : '0);

    // done on the last step, stays done while held
    assign mul_step   = valid_i & is_mul & (cur_cnt != LAST_STEP);
    assign mul_busy_o = mul_step;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (mul_step) begin
            cnt_q <= cur_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_step) begin
            acc_q   <= mul_sum;
            cand_q  <= cur_cand << 1;
            plier_q <= cur_plier >> 1;
        end
    end

    ////////////////////////////////////////
    // alu and branch

    always_comb begin
        case (pay_i.ctrl.alu_op)
            ALU_ADD:  result_o = pay_i.op1 + pay_i.op2;
            ALU_SUB:  result_o = pay_i.op1 - pay_i.op2;
            ALU_AND:  result_o = pay_i.op1 & pay_i.op2;
            ALU_OR:   result_o = pay_i.op1 | pay_i.op2;
            ALU_XOR:  result_o = pay_i.op1 ^ pay_i.op2;
            ALU_SLT:  result_o = word_t'($signed(pay_i.op1) < $signed(pay_i.op2));
            ALU_PASS: result_o = pay_i.op2;
            default:  result_o = mul_sum;
        endcase
        // link value
        if (pay_i.ctrl.br_op == BR_JAL) begin
            result_o = pay_i.pc + word_t'(4);
        end
    end

    always_comb begin
        case (pay_i.ctrl.br_op)
            BR_EQ:   taken_o = pay_i.op1 == pay_i.rs2;
            BR_NE:   taken_o = pay_i.op1 != pay_i.rs2;
            BR_LT:   taken_o = $signed(pay_i.op1) < $signed(pay_i.rs2);
            BR_JAL:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    // op2 holds the B or J offset here
    assign target_o = pay_i.pc + pay_i.op2;

endmodule

`default_nettype wire

// ==== verilog/operand_select.sv ====
`default_nettype none
`timescale 1ns/1ps

module operand_select (
    input  wire core_pkg::word_t regs_i [32],
    input  wire core_pkg::ctrl_t ctrl_i,
    input  wire core_pkg::word_t inst_i,
    input  wire core_pkg::word_t imm_i,
    input  wire core_pkg::fwd_t  fw_ex_i,
    input  wire core_pkg::fwd_t  fw_wb_i,
    output core_pkg::word_t      op1_o,
    output core_pkg::word_t      op2_o,
    output core_pkg::word_t      rs2_o
);
    import core_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;

    // youngest producer wins
    function automatic word_t pick(
        input reg_addr_t addr,
        input fwd_t      ex,
        input fwd_t      wb,
        input word_t     rf
    );
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex.valid && ex.rd == addr) begin
            val = ex.data;
        end else if (wb.valid && wb.rd == addr) begin
            val = wb.data;
        end else begin
            val = rf;
        end
        return val;
    endfunction

    assign rs1 = inst_i[19:15];
    assign rs2 = inst_i[24:20];

    assign rs1_val = pick(rs1, fw_ex_i, fw_wb_i, regs_i[rs1]);
    assign rs2_val = pick(rs2, fw_ex_i, fw_wb_i, regs_i[rs2]);

    assign op1_o = rs1_val;
    assign op2_o = ctrl_i.use_imm ? imm_i : rs2_val;
    assign rs2_o = rs2_val;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module reg_file (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   wen_i,
    input  wire [`REG_ADDR_W-1:0] waddr_i,
    input  wire [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]      regs_o [32]
);

    // x1..x31, x0 is hardwired
    logic [`XLEN-1:0] mem_q [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        regs_o[0] = '0;
        for (int i = 1; i < 32; i++) begin
            regs_o[i] = mem_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_defs.svh"

module inst_decoder (
    input  wire core_pkg::word_t inst_i,
    output core_pkg::ctrl_t      ctrl_o,
    output core_pkg::word_t      imm_o
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_w;
    word_t      imm_b_w;
    word_t      imm_j_w;
    word_t      imm_u_w;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i_w = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_w = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
    assign imm_j_w = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};
    assign imm_u_w = {inst_i[31:12], 12'b0};

    always_comb begin
        // unknown encodings fall out as a no-op
        ctrl_o = '{alu_op: ALU_ADD, br_op: BR_NONE, use_imm: 1'b0,
                   rf_wen: 1'b0, rd: inst_i[11:7]};
        imm_o  = imm_i_w;
        case (opcode)
            `OPC_OP: begin
                ctrl_o.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    {7'b0000001, 3'b000}: ctrl_o.alu_op = ALU_MUL;
                    default:              ctrl_o.rf_wen = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.use_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = ALU_ADD;
                    3'b111:  ctrl_o.alu_op = ALU_AND;
                    3'b110:  ctrl_o.alu_op = ALU_OR;
                    3'b100:  ctrl_o.alu_op = ALU_XOR;
                    default: ctrl_o.rf_wen = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                ctrl_o.alu_op  = ALU_PASS;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.rf_wen  = 1'b1;
                imm_o          = imm_u_w;
            end
            `OPC_BRANCH: begin
                // op2 carries the offset, rs2 goes to the compare
                ctrl_o.use_imm = 1'b1;
                imm_o          = imm_b_w;
                case (funct3)
                    3'b000:  ctrl_o.br_op = BR_EQ;
                    3'b001:  ctrl_o.br_op = BR_NE;
                    3'b100:  ctrl_o.br_op = BR_LT;
                    default: ctrl_o.br_op = BR_NONE;
                endcase
            end
            `OPC_JAL: begin
                ctrl_o.br_op   = BR_JAL;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.rf_wen  = 1'b1;
                imm_o          = imm_j_w;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = core_pkg::word_t
) (
    input  wire           clk,
    input  wire           arst_n_i,
    input  wire           flush_i,
    input  wire           hold_i,
    input  wire           bubble_i,
    input  wire           valid_i,
    input  wire payload_t data_i,
    output logic          valid_o,
    output logic          is_new_o,
    output payload_t      data_o
);

    // flush > hold > bubble > capture
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o  <= 1'b0;
            is_new_o <= 1'b0;
        end else if (flush_i) begin
            valid_o  <= 1'b0;
            is_new_o <= 1'b1;
        end else if (hold_i) begin
            is_new_o <= 1'b0;
        end else if (bubble_i) begin
            valid_o  <= 1'b0;
            is_new_o <= 1'b1;
        end else begin
            valid_o  <= valid_i;
            is_new_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush_i && !hold_i && !bubble_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS,
        ALU_MUL
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JAL
    } br_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        br_op_t    br_op;
        logic      use_imm;
        logic      rf_wen;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    ////////////////////////////////////////
    // stage payloads

    typedef struct packed {
        word_t pc;
        word_t inst;
    } id_pay_t;

    // inst kept for the rs1/rs2 fields
    typedef struct packed {
        word_t pc;
        word_t inst;
        ctrl_t ctrl;
        word_t imm;
    } ds_pay_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t op1;
        word_t op2;
        word_t rs2;
    } ex_pay_t;

    typedef struct packed {
        logic      rf_wen;
        reg_addr_t rd;
        word_t     data;
    } wb_pay_t;

endpackage

`default_nettype wire

// ==== verilog/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// execute cycles taken by one MUL
`define MUL_CYCLES  32

// opcode field values, inst[6:0]
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`endif
